/* source/fetch_pkg.sv */
// fetch_pkg: fetch widths, rv32i control-flow opcodes, b/j field layouts, instruction union
package fetch_pkg;

  localparam int PC_WD        = 32;  // pc and target width
  localparam int INST_WD      = 32;  // one rv32i instruction
  localparam int SRAM_DATA_WD = 64;  // inst sram read word

  // opcodes predecode cares about
  localparam logic [6:0] OPC_JAL    = 7'b110_1111;
  localparam logic [6:0] OPC_BRANCH = 7'b110_0011;
  localparam logic [6:0] OPC_JALR   = 7'b110_0111;

  // b-type layout, conditional branches
  typedef struct packed {
    logic       imm12;
    logic [5:0] imm10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm4_1;
    logic       imm11;
    logic [6:0] opcode;
  } rv_b_fmt_t;

  // j-type layout, jal
  typedef struct packed {
    logic       imm20;
    logic [9:0] imm10_1;
    logic       imm11;
    logic [7:0] imm19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } rv_j_fmt_t;

  // same 32-bit word seen raw or through either format
  typedef union packed {
    logic [INST_WD-1:0] raw;
    rv_b_fmt_t          b;
    rv_j_fmt_t          j;
  } rv_inst_u;

endpackage

/* source/pc_gen.sv */
// pc_gen: pre-fetch pc register, redirect and stall handling, inst sram request side
module pc_gen
  import fetch_pkg::*;
#(
  parameter logic [PC_WD-1:0] PC_RESETVAL = 32'h0000_0000
) (
  input  logic             i_clk,
  input  logic             i_arst_n,
  // branch bus from the back end
  input  logic             i_br_stall,
  input  logic             i_br_taken,
  input  logic [PC_WD-1:0] i_br_target,
  // room in fetch
  input  logic             i_fs_allowin,
  // inst sram request
  input  logic             i_inst_sram_addr_ok,
  output logic             o_inst_sram_req,
  output logic [PC_WD-1:0] o_inst_sram_addr,
  // accepted request to fetch
  output logic             o_pg_issue,
  output logic [PC_WD-1:0] o_pg_pc
);

  logic [PC_WD-1:0] pc_q;      // next pc to fetch
  logic             run_q;     // low during reset, keeps req quiet
  logic             accept;

  // a redirect drops any pending request, the target is fetched next cycle
  assign o_inst_sram_req  = run_q & i_fs_allowin & ~i_br_stall & ~i_br_taken;
  assign o_inst_sram_addr = {pc_q[PC_WD-1:3], 3'b000};  // 64-bit aligned word

  assign accept     = o_inst_sram_req & i_inst_sram_addr_ok;
  assign o_pg_issue = accept;
  assign o_pg_pc    = pc_q;

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      run_q <= 1'b0;
    end else begin
      run_q <= 1'b1;
    end
  end

  // redirect wins over sequential advance
  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      pc_q <= PC_RESETVAL;
    end else if (i_br_taken) begin
      pc_q <= i_br_target;
    end else if (accept) begin
      pc_q <= pc_q + PC_WD'(4);
    end
  end

endmodule

/* source/fetch_stage.sv */
// fetch_stage: one-slot fetch, outstanding request tracking, flushed response drop, half select
module fetch_stage
  import fetch_pkg::*;
(
  input  logic                    i_clk,
  input  logic                    i_arst_n,
  input  logic                    i_br_taken,
  // from pc_gen
  input  logic                    i_pg_issue,
  input  logic [PC_WD-1:0]        i_pg_pc,
  // inst sram response
  input  logic                    i_inst_sram_data_ok,
  input  logic [SRAM_DATA_WD-1:0] i_inst_sram_rdata,
  // toward predecode
  input  logic                    i_pd_allowin,
  output logic                    o_fs_allowin,
  output logic                    o_fs_valid,
  output logic [INST_WD-1:0]      o_fs_inst,
  output logic [PC_WD-1:0]        o_fs_pc
);

  logic               fs_valid_q;  // slot holds an instruction
  logic               wait_q;      // request out, data not back yet
  logic               drop_q;      // orphaned response still on its way
  logic [PC_WD-1:0]   pc_q;
  logic [INST_WD-1:0] inst_q;

  logic               data_hit;    // response for the live slot
  logic               fs_leave;
  logic [INST_WD-1:0] inst_half;

  assign data_hit = wait_q & i_inst_sram_data_ok;
  assign fs_leave = fs_valid_q & i_pd_allowin;

  // sram word is 8-byte aligned, pc[2] picks the upper word
  assign inst_half = pc_q[2] ? i_inst_sram_rdata[SRAM_DATA_WD-1:INST_WD]
                             : i_inst_sram_rdata[INST_WD-1:0];

  // empty slot with nothing in flight, or the held instruction moves on
  assign o_fs_allowin = (~fs_valid_q & ~wait_q & ~drop_q) | fs_leave;

  assign o_fs_valid = fs_valid_q;
  assign o_fs_inst  = inst_q;
  assign o_fs_pc    = pc_q;

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      fs_valid_q <= 1'b0;
      wait_q     <= 1'b0;
      drop_q     <= 1'b0;
    end else if (i_br_taken) begin
      // flush, remember a response that is still coming
      fs_valid_q <= 1'b0;
      wait_q     <= 1'b0;
      drop_q     <= (drop_q | wait_q) & ~i_inst_sram_data_ok;
    end else begin
      if (i_pg_issue) begin
        wait_q <= 1'b1;
      end else if (data_hit) begin
        wait_q <= 1'b0;
      end

      if (data_hit) begin
        fs_valid_q <= 1'b1;   // valid the cycle after data_ok
      end else if (fs_leave) begin
        fs_valid_q <= 1'b0;
      end

      if (drop_q && i_inst_sram_data_ok) begin
        drop_q <= 1'b0;       // orphan absorbed, slot free next cycle
      end
    end
  end

  // payload, no reset
  always_ff @(posedge i_clk) begin
    if (i_pg_issue) begin
      pc_q <= i_pg_pc;
    end
    if (data_hit) begin
      inst_q <= inst_half;
    end
  end

endmodule

/* source/predecode_stage.sv */
// predecode_stage: decode-facing output register, branch classify and target, credit counter
module predecode_stage
  import fetch_pkg::*;
#(
  parameter int FD_CREDITS = 4
) (
  input  logic               i_clk,
  input  logic               i_arst_n,
  input  logic               i_br_taken,
  // from fetch
  input  logic               i_fs_valid,
  input  logic [INST_WD-1:0] i_fs_inst,
  input  logic [PC_WD-1:0]   i_fs_pc,
  // credit return from decode
  input  logic               i_fd_credit,
  output logic               o_pd_allowin,
  // to decode
  output logic               o_fd_valid,
  output logic [INST_WD-1:0] o_fd_inst,
  output logic [PC_WD-1:0]   o_fd_pc,
  output logic               o_fd_is_branch,
  output logic [PC_WD-1:0]   o_fd_target
);

  localparam int CRD_WD = $clog2(FD_CREDITS + 1);

  logic              pd_valid_q;
  logic [CRD_WD-1:0] credit_q;   // free entries in decode's queue
  rv_inst_u          inst_q;
  logic [PC_WD-1:0]  pc_q;

  logic              fd_send;
  logic              fs_take;
  logic [PC_WD-1:0]  imm_b;
  logic [PC_WD-1:0]  imm_j;

  assign fd_send      = pd_valid_q & (credit_q != '0);
  assign o_pd_allowin = ~pd_valid_q | fd_send;
  assign fs_take      = i_fs_valid & o_pd_allowin;

  assign o_fd_valid = fd_send;
  assign o_fd_inst  = inst_q.raw;
  assign o_fd_pc    = pc_q;

  // sign-extended immediates, both views of the same word
  assign imm_b = {{19{inst_q.b.imm12}}, inst_q.b.imm12, inst_q.b.imm11,
                  inst_q.b.imm10_5, inst_q.b.imm4_1, 1'b0};
  assign imm_j = {{11{inst_q.j.imm20}}, inst_q.j.imm20, inst_q.j.imm19_12,
                  inst_q.j.imm11, inst_q.j.imm10_1, 1'b0};

  always_comb begin
    o_fd_is_branch = 1'b1;
    o_fd_target    = pc_q + PC_WD'(4);
    case (inst_q.b.opcode)
      OPC_BRANCH: o_fd_target = pc_q + imm_b;
      OPC_JAL:    o_fd_target = pc_q + imm_j;
      OPC_JALR:   o_fd_target = '0;      // target needs rs1, resolved later
      default:    o_fd_is_branch = 1'b0;
    endcase
  end

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      pd_valid_q <= 1'b0;
    end else if (i_br_taken) begin
      pd_valid_q <= 1'b0;           // wrong path
    end else if (o_pd_allowin) begin
      pd_valid_q <= i_fs_valid;
    end
  end

  // send and credit in one cycle cancel out
  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      credit_q <= CRD_WD'(FD_CREDITS);
    end else begin
      case ({fd_send, i_fd_credit})
        2'b10:   credit_q <= credit_q - 1'b1;
        2'b01:   credit_q <= credit_q + 1'b1;
        default: credit_q <= credit_q;
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (fs_take) begin
      inst_q <= i_fs_inst;
      pc_q   <= i_fs_pc;
    end
  end

endmodule

/* source/fetch_top.sv */
// fetch_top: instruction fetch front end, pc_gen + fetch_stage + predecode_stage
module fetch_top
  import fetch_pkg::*;
#(
  parameter logic [PC_WD-1:0] PC_RESETVAL = 32'h8000_0000,
  parameter int               FD_CREDITS  = 4
) (
  input  logic                    i_clk,
  input  logic                    i_arst_n,
  // branch bus
  input  logic                    i_br_stall,
  input  logic                    i_br_taken,
  input  logic [PC_WD-1:0]        i_br_target,
  // inst sram
  output logic                    o_inst_sram_req,
  output logic [PC_WD-1:0]        o_inst_sram_addr,
  input  logic                    i_inst_sram_addr_ok,
  input  logic                    i_inst_sram_data_ok,
  input  logic [SRAM_DATA_WD-1:0] i_inst_sram_rdata,
  // decode side
  input  logic                    i_fd_credit,
  output logic                    o_fd_valid,
  output logic [INST_WD-1:0]      o_fd_inst,
  output logic [PC_WD-1:0]        o_fd_pc,
  output logic                    o_fd_is_branch,
  output logic [PC_WD-1:0]        o_fd_target
);

  logic               pg_issue;
  logic [PC_WD-1:0]   pg_pc;
  logic               fs_allowin;
  logic               fs_valid;
  logic [INST_WD-1:0] fs_inst;
  logic [PC_WD-1:0]   fs_pc;
  logic               pd_allowin;

  pc_gen #(
    .PC_RESETVAL         (PC_RESETVAL)
  ) u_pc_gen (
    .i_clk               (i_clk),
    .i_arst_n            (i_arst_n),
    .i_br_stall          (i_br_stall),
    .i_br_taken          (i_br_taken),
    .i_br_target         (i_br_target),
    .i_fs_allowin        (fs_allowin),
    .i_inst_sram_addr_ok (i_inst_sram_addr_ok),
    .o_inst_sram_req     (o_inst_sram_req),
    .o_inst_sram_addr    (o_inst_sram_addr),
    .o_pg_issue          (pg_issue),
    .o_pg_pc             (pg_pc)
  );

  fetch_stage u_fetch_stage (
    .i_clk               (i_clk),
    .i_arst_n            (i_arst_n),
    .i_br_taken          (i_br_taken),
    .i_pg_issue          (pg_issue),
    .i_pg_pc             (pg_pc),
    .i_inst_sram_data_ok (i_inst_sram_data_ok),
    .i_inst_sram_rdata   (i_inst_sram_rdata),
    .i_pd_allowin        (pd_allowin),
    .o_fs_allowin        (fs_allowin),
    .o_fs_valid          (fs_valid),
    .o_fs_inst           (fs_inst),
    .o_fs_pc             (fs_pc)
  );

  predecode_stage #(
    .FD_CREDITS          (FD_CREDITS)
  ) u_predecode_stage (
    .i_clk               (i_clk),
    .i_arst_n            (i_arst_n),
    .i_br_taken          (i_br_taken),
    .i_fs_valid          (fs_valid),
    .i_fs_inst           (fs_inst),
    .i_fs_pc             (fs_pc),
    .i_fd_credit         (i_fd_credit),
    .o_pd_allowin        (pd_allowin),
    .o_fd_valid          (o_fd_valid),
    .o_fd_inst           (o_fd_inst),
    .o_fd_pc             (o_fd_pc),
    .o_fd_is_branch      (o_fd_is_branch),
    .o_fd_target         (o_fd_target)
  );

endmodule

/* bench/inst_sram_model.sv */
// inst_sram_model: 64-bit instruction sram, random addr_ok, next-cycle in-order data, patchable words
module inst_sram_model
  import fetch_pkg::*;
(
  input  logic                    i_clk,
  input  logic                    i_arst_n,
  input  logic                    i_req,
  input  logic [PC_WD-1:0]        i_addr,
  output logic                    o_addr_ok,
  output logic                    o_data_ok,
  output logic [SRAM_DATA_WD-1:0] o_rdata
);
  timeunit 1ns;
  timeprecision 100ps;

  integer             seed = 32'h96947507;
  logic [INST_WD-1:0] patch [logic [PC_WD-1:0]];  // words placed by the tests

  // fill pattern, every address bit matters, opcode stays addi
  function automatic logic [INST_WD-1:0] word_at(input logic [PC_WD-1:0] a);
    if (patch.exists(a)) begin
      return patch[a];
    end
    return {a[31:7] ^ {a[6:0], 18'h2d3c1}, 7'h13};
  endfunction

  task automatic set_word(input logic [PC_WD-1:0] a, input logic [INST_WD-1:0] w);
    patch[a] = w;
  endtask

  initial o_addr_ok = 1'b0;

  always @(negedge i_clk) begin
    o_addr_ok <= ($random(seed) & 3) != 0;  // accepts about 3 of 4 cycles
  end

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_data_ok <= 1'b0;
      o_rdata   <= '0;
    end else begin
      o_data_ok <= i_req & o_addr_ok;
      if (i_req && o_addr_ok) begin
        o_rdata <= {word_at(i_addr + 32'd4), word_at(i_addr)};
      end
    end
  end

endmodule

/* bench/fetch_checker.sv */
// fetch_checker: credit bounds, send-with-credit and request address stability assertions, binds
module fetch_checker #(
  parameter int FD_CREDITS = 15,
  parameter int CRD_WD     = 4
) (
  input logic              i_clk,
  input logic              i_arst_n,
  input logic [CRD_WD-1:0] i_credit,
  input logic              i_send,
  input logic              i_credit_ret,
  input logic              i_req,
  input logic              i_addr_ok,
  input logic [31:0]       i_addr
);
  timeunit 1ns;
  timeprecision 100ps;

  int free_q;  // free decode entries, counted from the pins

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      free_q <= FD_CREDITS;
    end else begin
      free_q <= free_q - int'(i_send) + int'(i_credit_ret);
    end
  end

  a_credit_max: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    int'(i_credit) <= FD_CREDITS)
    else $error("credit counter above queue depth");

  a_send_credit: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    i_send |-> free_q != 0)
    else $error("send to decode without credit");

  // a dropped request may come back elsewhere, a held one may not move
  a_addr_stable: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    (i_req && !i_addr_ok) |=> (!i_req || $stable(i_addr)))
    else $error("request address moved before acceptance");

endmodule

bind predecode_stage fetch_checker #(
  .FD_CREDITS (FD_CREDITS),
  .CRD_WD     (CRD_WD)
) u_credit_chk (
  .i_clk        (i_clk),
  .i_arst_n     (i_arst_n),
  .i_credit     (credit_q),
  .i_send       (o_fd_valid),
  .i_credit_ret (i_fd_credit),
  .i_req        (1'b0),
  .i_addr_ok    (1'b0),
  .i_addr       (32'h0)
);

bind pc_gen fetch_checker u_req_chk (
  .i_clk        (i_clk),
  .i_arst_n     (i_arst_n),
  .i_credit     (4'h0),
  .i_send       (1'b0),
  .i_credit_ret (1'b0),
  .i_req        (o_inst_sram_req),
  .i_addr_ok    (i_inst_sram_addr_ok),
  .i_addr       (o_inst_sram_addr)
);

/* bench/fetch_tb.sv */
// fetch_tb: clock, reset, directed fetch tests, compare tasks, timeout and verdict
module fetch_tb
  import fetch_pkg::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  localparam logic [PC_WD-1:0] PC_START = 32'h8000_0000;
  localparam int               CREDITS  = 4;
  // five tests need roughly 400 cycles, ten times that for margin
  localparam int               TIMEOUT_CYCLES = 4000;

  logic                    clk = 1'b0;
  logic                    arst_n = 1'b0;
  logic                    br_stall = 1'b0;
  logic                    br_taken = 1'b0;
  logic [PC_WD-1:0]        br_target = '0;
  logic                    fd_credit = 1'b0;
  logic                    sram_req;
  logic [PC_WD-1:0]        sram_addr;
  logic                    sram_addr_ok;
  logic                    sram_data_ok;
  logic [SRAM_DATA_WD-1:0] sram_rdata;
  logic                    fd_valid;
  logic [INST_WD-1:0]      fd_inst;
  logic [PC_WD-1:0]        fd_pc;
  logic                    fd_is_branch;
  logic [PC_WD-1:0]        fd_target;

  integer           seed = 32'h96947507;
  int               cycles = 0;
  int               owed = 0;           // credits still to hand back
  bit               credit_auto = 1'b1;
  logic [PC_WD-1:0] exp_pc = PC_START;  // next pc in program order

  logic [PC_WD-1:0]   q_pc[$];
  logic [INST_WD-1:0] q_inst[$];
  logic               q_br[$];
  logic [PC_WD-1:0]   q_tgt[$];

  fetch_top #(
    .PC_RESETVAL         (PC_START),
    .FD_CREDITS          (CREDITS)
  ) DUT (
    .i_clk               (clk),
    .i_arst_n            (arst_n),
    .i_br_stall          (br_stall),
    .i_br_taken          (br_taken),
    .i_br_target         (br_target),
    .o_inst_sram_req     (sram_req),
    .o_inst_sram_addr    (sram_addr),
    .i_inst_sram_addr_ok (sram_addr_ok),
    .i_inst_sram_data_ok (sram_data_ok),
    .i_inst_sram_rdata   (sram_rdata),
    .i_fd_credit         (fd_credit),
    .o_fd_valid          (fd_valid),
    .o_fd_inst           (fd_inst),
    .o_fd_pc             (fd_pc),
    .o_fd_is_branch      (fd_is_branch),
    .o_fd_target         (fd_target)
  );

  inst_sram_model u_sram (
    .i_clk     (clk),
    .i_arst_n  (arst_n),
    .i_req     (sram_req),
    .i_addr    (sram_addr),
    .o_addr_ok (sram_addr_ok),
    .o_data_ok (sram_data_ok),
    .o_rdata   (sram_rdata)
  );

  initial begin
    forever #4 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout, fetch stopped delivering instructions");
      $display("=== FAIL ===");
      $fatal(1);
    end
  end

  // decode model: collect sends mid-cycle, hand credits back
  always @(negedge clk) begin
    if (fd_valid) begin
      q_pc.push_back(fd_pc);
      q_inst.push_back(fd_inst);
      q_br.push_back(fd_is_branch);
      q_tgt.push_back(fd_target);
      if (credit_auto) owed++;
    end
    if (owed > 0) begin
      fd_credit = 1'b1;
      owed--;
    end else begin
      fd_credit = 1'b0;
    end
  end

  task automatic check_pc(input string name, input logic [PC_WD-1:0] exp_v,
                          input logic [PC_WD-1:0] act_v);
    if (exp_v !== act_v) begin
      $display("Error at %0t: %s expected %h got %h", $time, name, exp_v, act_v);
      $display("=== FAIL ===");
      $fatal(1);
    end
  endtask

  task automatic check_inst(input string name, input rv_inst_u exp_v, input rv_inst_u act_v);
    if (exp_v.raw !== act_v.raw) begin
      $display("Error at %0t: %s expected %h got %h", $time, name, exp_v.raw, act_v.raw);
      $display("=== FAIL ===");
      $fatal(1);
    end
  endtask

  task automatic check_flag(input string name, input logic exp_v, input logic act_v);
    if (exp_v !== act_v) begin
      $display("Error at %0t: %s expected %b got %b", $time, name, exp_v, act_v);
      $display("=== FAIL ===");
      $fatal(1);
    end
  endtask

  // the 64-bit sram word holding pc, then the half that pc[2] picks
  function automatic rv_inst_u fetched_word(input logic [PC_WD-1:0] pc);
    logic [PC_WD-1:0]        base;
    logic [SRAM_DATA_WD-1:0] dword;
    rv_inst_u                w;
    base    = {pc[PC_WD-1:3], 3'b000};
    dword   = {u_sram.word_at(base + 32'd4), u_sram.word_at(base)};
    w.raw   = pc[2] ? dword[63:32] : dword[31:0];
    return w;
  endfunction

  function automatic logic cf_expected(input rv_inst_u w);
    return (w.raw[6:0] == OPC_BRANCH) || (w.raw[6:0] == OPC_JAL) ||
           (w.raw[6:0] == OPC_JALR);
  endfunction

  function automatic logic [PC_WD-1:0] target_expected(input rv_inst_u w,
                                                       input logic [PC_WD-1:0] pc);
    logic signed [12:0] b_off;
    logic signed [20:0] j_off;
    b_off = {w.b.imm12, w.b.imm11, w.b.imm10_5, w.b.imm4_1, 1'b0};
    j_off = {w.j.imm20, w.j.imm19_12, w.j.imm11, w.j.imm10_1, 1'b0};
    if (w.raw[6:0] == OPC_BRANCH) return pc + 32'(b_off);
    if (w.raw[6:0] == OPC_JAL) return pc + 32'(j_off);
    if (w.raw[6:0] == OPC_JALR) return '0;
    return pc + 32'd4;
  endfunction

  // pop one send, check it is the next instruction in program order
  task automatic next_seq(output logic br, output logic [PC_WD-1:0] tgt);
    logic [PC_WD-1:0] pc;
    rv_inst_u         inst;
    while (q_pc.size() == 0) @(posedge clk);
    pc       = q_pc.pop_front();
    inst.raw = q_inst.pop_front();
    br       = q_br.pop_front();
    tgt      = q_tgt.pop_front();
    check_pc("o_fd_pc", exp_pc, pc);
    check_inst("o_fd_inst", fetched_word(exp_pc), inst);
    exp_pc = exp_pc + 32'd4;
  endtask

  task automatic expect_seq(input int n);
    logic             br;
    logic [PC_WD-1:0] tgt;
    repeat (n) next_seq(br, tgt);
  endtask

  task automatic drain_seq();
    while (q_pc.size() > 0) expect_seq(1);
  endtask

  // one taken pulse, only the send of the pulse cycle may still be old path
  task automatic redirect_to(input logic [PC_WD-1:0] tgt);
    @(posedge clk);
    drain_seq();
    @(negedge clk);
    br_taken  = 1'b1;
    br_target = tgt;
    @(posedge clk);
    drain_seq();  // pulse-cycle send, still in program order
    exp_pc = tgt;
    @(negedge clk);
    br_taken  = 1'b0;
  endtask

  task automatic reset_and_sequential();
    @(negedge clk);
    check_flag("o_inst_sram_req", 1'b0, sram_req);
    check_flag("o_fd_valid", 1'b0, fd_valid);
    repeat (15) @(negedge clk);
    arst_n = 1'b1;
    expect_seq(12);
  endtask

  task automatic credit_backpressure();
    @(posedge clk);
    drain_seq();
    credit_auto = 1'b0;
    while (q_pc.size() < CREDITS) @(posedge clk);
    repeat (50) @(posedge clk);
    if (q_pc.size() != CREDITS) begin
      $display("sent %0d instructions without credit, depth is %0d", q_pc.size(), CREDITS);
      $display("=== FAIL ===");
      $fatal(1);
    end
    expect_seq(CREDITS);
    owed = owed + CREDITS;
    credit_auto = 1'b1;
    expect_seq(8);
  endtask

  task automatic random_redirect();
    int k;
    k = 4 + ($random(seed) & 15);
    repeat (k) begin
      @(posedge clk);
      drain_seq();
    end
    redirect_to(32'h8000_4000);
    expect_seq(8);
  endtask

  task automatic stall_hold();
    @(negedge clk);
    br_stall = 1'b1;
    repeat (30) begin
      @(posedge clk);
      drain_seq();
      @(negedge clk);
      check_flag("o_inst_sram_req", 1'b0, sram_req);
    end
    br_stall = 1'b0;
    expect_seq(6);
  endtask

  task automatic predecode_kinds();
    logic [PC_WD-1:0] base;
    logic [PC_WD-1:0] pc;
    logic [PC_WD-1:0] tgt;
    logic             br;
    rv_inst_u         w;
    base = 32'h8000_8000;
    w.raw = '0;
    w.b.imm12 = 1'b1;  // beq x1, x2, -16
    w.b.imm11 = 1'b1;
    w.b.imm10_5 = 6'h3f;
    w.b.imm4_1 = 4'h8;
    w.b.rs1 = 5'd1;
    w.b.rs2 = 5'd2;
    w.b.opcode = OPC_BRANCH;
    u_sram.set_word(base, w.raw);
    w.raw = '0;
    w.j.imm10_1 = 10'h155;
    w.j.imm11 = 1'b1;
    w.j.imm19_12 = 8'h12;
    w.j.rd = 5'd1;
    w.j.opcode = OPC_JAL;
    u_sram.set_word(base + 32'd4, w.raw);
    u_sram.set_word(base + 32'd8, {12'h010, 5'd1, 3'b000, 5'd0, OPC_JALR});
    u_sram.set_word(base + 32'd12, 32'h0050_0093);  // addi x1, x0, 5
    redirect_to(base);
    repeat (4) begin
      pc = exp_pc;
      w  = fetched_word(pc);
      next_seq(br, tgt);
      check_flag("o_fd_is_branch", cf_expected(w), br);
      check_pc("o_fd_target", target_expected(w, pc), tgt);
    end
  endtask

  initial begin
    reset_and_sequential();
    credit_backpressure();
    random_redirect();
    stall_hold();
    predecode_kinds();
    $display("=== PASS ===");
    $finish;
  end

endmodule

/* files.f */
source/fetch_pkg.sv
source/pc_gen.sv
source/fetch_stage.sv
source/predecode_stage.sv
source/fetch_top.sv
bench/inst_sram_model.sv
bench/fetch_checker.sv
bench/fetch_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the fetch front end testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --top-module fetch_tb -f files.f -o fetch_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/fetch_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "=== FAIL ===" "$LOG"; then
  echo "testbench reported failure"
  exit 1
fi
if ! grep -q "=== PASS ===" "$LOG"; then
  echo "no verdict in $LOG"
  exit 1
fi
exit 0
